//--- Bender.yml
package:
  name: cpu16_pipe

sources:
  # Packages first, then stages, then the top level
  - src/cpu_isa_pkg.sv
  - src/cpu_pipe_pkg.sv
  - src/fetch_ctrl.sv
  - src/decode_stage.sv
  - src/forward_unit.sv
  - src/execute_stage.sv
  - src/retire_stage.sv
  - src/cpu.sv
  - target: test
    files:
      - tests/cpu_tb.sv

//--- build.f
src/cpu_isa_pkg.sv
src/cpu_pipe_pkg.sv
src/fetch_ctrl.sv
src/decode_stage.sv
src/forward_unit.sv
src/execute_stage.sv
src/retire_stage.sv
src/cpu.sv
tests/cpu_tb.sv

//--- src/cpu.sv
// CPU top level
// Five-stage in-order pipeline: fetch, decode, execute, memory slot,
// writeback. Instructions are served from outside at pc

`timescale 1ns/1ps

module cpu
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic [data_w-1:0] instr,   // Word at pc, same cycle
    output logic [data_w-1:0] pc,
    output logic              hlt,
    output wb_t               wb       // Retiring register write
);

    // ------------------------------------------------------------------
    // Stage wiring
    // ------------------------------------------------------------------
    logic                  fetch_valid;
    logic                  halt_seen;      // Decode to fetch
    logic                  halt_retired;   // MEM/WB to fetch
    id_ex_t                id;
    logic [reg_addr_w-1:0] id_rs;
    logic [reg_addr_w-1:0] id_rt;
    logic [data_w-1:0]     id_a;
    logic [data_w-1:0]     id_b;
    logic [data_w-1:0]     fwd_a;
    logic [data_w-1:0]     fwd_b;
    ex_mem_t               ex;
    ex_mem_t               ex_mem;
    mem_wb_t               mem_wb;

    fetch_ctrl fetch_i (
        .clk          (clk),
        .rst          (rst),
        .halt_seen    (halt_seen),
        .halt_retired (halt_retired),
        .pc           (pc),
        .fetch_valid  (fetch_valid),
        .hlt          (hlt)
    );

    decode_stage decode_i (
        .clk         (clk),
        .rst         (rst),
        .instr       (instr),
        .fetch_valid (fetch_valid),
        .wb          (wb),            // Register file write
        .halt_seen   (halt_seen),
        .id          (id)
    );

    forward_unit forward_i (
        .id_rs  (id_rs),
        .id_rt  (id_rt),
        .id_a   (id_a),
        .id_b   (id_b),
        .ex_mem (ex_mem),
        .mem_wb (mem_wb),
        .fwd_a  (fwd_a),
        .fwd_b  (fwd_b)
    );

    execute_stage execute_i (
        .clk   (clk),
        .rst   (rst),
        .id    (id),
        .fwd_a (fwd_a),
        .fwd_b (fwd_b),
        .id_rs (id_rs),
        .id_rt (id_rt),
        .id_a  (id_a),
        .id_b  (id_b),
        .ex    (ex)
    );

    retire_stage retire_i (
        .clk          (clk),
        .rst          (rst),
        .ex           (ex),
        .ex_mem       (ex_mem),
        .mem_wb       (mem_wb),
        .wb           (wb),
        .halt_retired (halt_retired)
    );

endmodule

//--- src/cpu_isa_pkg.sv
// ISA definitions for the 16-bit in-order pipeline
// Data and register widths, opcode map and the instruction word layout
// One instruction word decodes two ways through a packed union

package cpu_isa_pkg;

    // ------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------
    localparam int data_w     = 16;   // Data word
    localparam int reg_addr_w = 4;    // Register specifier
    localparam int reg_count  = 16;
    localparam int imm_w      = 8;    // LDI / LHB immediate
    localparam int op_w       = 4;    // Opcode field

    // ------------------------------------------------------------------
    // Opcodes, unlisted codes run as NOP
    // ------------------------------------------------------------------
    localparam logic [op_w-1:0] op_add = 4'h0;
    localparam logic [op_w-1:0] op_sub = 4'h1;
    localparam logic [op_w-1:0] op_and = 4'h2;
    localparam logic [op_w-1:0] op_xor = 4'h3;
    localparam logic [op_w-1:0] op_sll = 4'h4;
    localparam logic [op_w-1:0] op_ldi = 4'h8;   // rd = zext(imm8)
    localparam logic [op_w-1:0] op_lhb = 4'h9;   // rd[15:8] = imm8
    localparam logic [op_w-1:0] op_nop = 4'he;
    localparam logic [op_w-1:0] op_hlt = 4'hf;

    // R view of the word
    typedef struct packed {
        logic [op_w-1:0]       opcode;
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] rs;
        logic [reg_addr_w-1:0] rt;
    } instr_r_t;

    // I view, imm8 sits where rs/rt were
    typedef struct packed {
        logic [op_w-1:0]       opcode;
        logic [reg_addr_w-1:0] rd;
        logic [imm_w-1:0]      imm8;
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

endpackage

//--- src/cpu_pipe_pkg.sv
// Pipeline definitions
// Stage register layouts, the writeback port and forwarding select codes

package cpu_pipe_pkg;

    import cpu_isa_pkg::*;

    // ------------------------------------------------------------------
    // Forwarding selects for one ALU operand
    // ------------------------------------------------------------------
    localparam logic [1:0] fwd_sel_none  = 2'b00;   // Register file value
    localparam logic [1:0] fwd_sel_exmem = 2'b10;   // One instruction ahead
    localparam logic [1:0] fwd_sel_memwb = 2'b01;   // Two instructions ahead

    // Decoded operation held in ID/EX
    typedef struct packed {
        logic                  valid;
        logic [op_w-1:0]       op;
        logic [reg_addr_w-1:0] rs;          // Source A specifier (rd for LHB)
        logic [reg_addr_w-1:0] rt;          // Source B specifier
        logic [reg_addr_w-1:0] rd;
        logic                  reg_write;
        logic [data_w-1:0]     a;           // Register file values
        logic [data_w-1:0]     b;
        logic [imm_w-1:0]      imm;
    } id_ex_t;

    // Result slot, same shape after EX and after the memory slot
    typedef struct packed {
        logic                  valid;
        logic                  reg_write;
        logic [reg_addr_w-1:0] dst;
        logic [data_w-1:0]     result;
        logic                  halt;        // HLT travelling down
    } ex_mem_t;

    typedef ex_mem_t mem_wb_t;

    // Architectural register write
    typedef struct packed {
        logic                  en;
        logic [reg_addr_w-1:0] dst;
        logic [data_w-1:0]     data;
    } wb_t;

endpackage

//--- src/decode_stage.sv
// Decode stage
// IF/ID register, field decode through the R and I views, and the
// 16-entry register file with write-through to both read ports

`timescale 1ns/1ps

module decode_stage
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  instr_u instr,         // From the instruction source
    input  logic   fetch_valid,
    input  wb_t    wb,            // Write port from MEM/WB
    output logic   halt_seen,
    output id_ex_t id
);

    instr_u                if_instr;            // IF/ID payload
    logic                  if_valid;
    logic [data_w-1:0]     regs [reg_count];
    logic [op_w-1:0]       op;
    logic [reg_addr_w-1:0] src_a;
    logic [reg_addr_w-1:0] src_b;

    // True for opcodes that write rd
    function automatic logic op_writes(input logic [op_w-1:0] code);
        logic w;
        case (code)
            op_add, op_sub, op_and, op_xor, op_sll: w = 1'b1;
            op_ldi, op_lhb:                         w = 1'b1;
            op_nop, op_hlt:                         w = 1'b0;
            default:                                w = 1'b0;   // Unused codes
        endcase
        return w;
    endfunction

    // Read port, r0 is zero, same-cycle write wins
    function automatic logic [data_w-1:0] rf_read(input logic [reg_addr_w-1:0] addr);
        logic [data_w-1:0] val;
        if (addr == '0) begin
            val = '0;
        end else if (wb.en && (wb.dst == addr)) begin
            val = wb.data;
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    // ------------------------------------------------------------------
    // IF/ID register
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            if_valid <= 1'b0;
        end else begin
            if_valid <= fetch_valid;   // Bubble once fetch is dropped
        end
    end

    always_ff @(posedge clk) begin
        if_instr <= instr;
    end

    // ------------------------------------------------------------------
    // Register file
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en && (wb.dst != '0)) begin
            regs[wb.dst] <= wb.data;   // r0 stays zero
        end
    end

    // ------------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------------
    always_comb begin
        op    = if_instr.r.opcode;
        // LHB keeps the low byte of rd, so rd is read on port A
        src_a = (op == op_lhb) ? if_instr.i.rd : if_instr.r.rs;
        src_b = if_instr.r.rt;

        id.valid     = if_valid;
        id.op        = op;
        id.rs        = src_a;
        id.rt        = src_b;
        id.rd        = if_instr.r.rd;
        id.reg_write = if_valid && op_writes(op) && (if_instr.r.rd != '0);
        id.a         = rf_read(src_a);
        id.b         = rf_read(src_b);
        id.imm       = if_instr.i.imm8;   // Only meaningful in the I view

        halt_seen = if_valid && (op == op_hlt);
    end

    // Next IF/ID is always a bubble after a decoded HLT
    a_halt_once: assert property (@(posedge clk) disable iff (rst)
        halt_seen |=> !halt_seen);

endmodule

//--- src/execute_stage.sv
// Execute stage
// ID/EX register and the ALU, fed with forwarded operands

`timescale 1ns/1ps

module execute_stage
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  id_ex_t                id,
    input  logic [data_w-1:0]     fwd_a,
    input  logic [data_w-1:0]     fwd_b,
    output logic [reg_addr_w-1:0] id_rs,    // To forward_unit
    output logic [reg_addr_w-1:0] id_rt,
    output logic [data_w-1:0]     id_a,
    output logic [data_w-1:0]     id_b,
    output ex_mem_t               ex
);

    id_ex_t            idx;    // ID/EX register
    logic [data_w-1:0] alu;

    // ------------------------------------------------------------------
    // ID/EX register
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            idx.valid     <= 1'b0;
            idx.reg_write <= 1'b0;
        end else begin
            idx <= id;
        end
    end

    assign id_rs = idx.rs;
    assign id_rt = idx.rt;
    assign id_a  = idx.a;
    assign id_b  = idx.b;

    // ------------------------------------------------------------------
    // ALU
    // ------------------------------------------------------------------
    always_comb begin
        case (idx.op)
            op_add:  alu = fwd_a + fwd_b;              // Wraps at 16 bits
            op_sub:  alu = fwd_a - fwd_b;
            op_and:  alu = fwd_a & fwd_b;
            op_xor:  alu = fwd_a ^ fwd_b;
            op_sll:  alu = fwd_a << fwd_b[3:0];
            op_ldi:  alu = {{(data_w-imm_w){1'b0}}, idx.imm};
            op_lhb:  alu = {idx.imm, fwd_a[imm_w-1:0]};   // fwd_a holds old rd
            default: alu = '0;                         // NOP, HLT, unused
        endcase
    end

    always_comb begin
        ex.valid     = idx.valid;
        ex.reg_write = idx.valid && idx.reg_write;
        ex.dst       = idx.rd;
        ex.result    = alu;
        ex.halt      = idx.valid && (idx.op == op_hlt);
    end

endmodule

//--- src/fetch_ctrl.sv
// Fetch controller
// Holds the PC and the run / drain / halted state machine
// A decoded HLT freezes fetch, the retiring HLT raises hlt

`timescale 1ns/1ps

module fetch_ctrl
    import cpu_isa_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              halt_seen,      // Valid HLT in IF/ID
    input  logic              halt_retired,   // HLT in MEM/WB
    output logic [data_w-1:0] pc,
    output logic              fetch_valid,
    output logic              hlt
);

    typedef enum logic [1:0] {
        st_run,
        st_drain,
        st_halted
    } state_t;

    state_t state;

    // ------------------------------------------------------------------
    // State and PC
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_run;
            pc    <= '0;
        end else begin
            case (state)
                st_run: begin
                    if (halt_seen) begin
                        state <= st_drain;     // PC stays on the word after HLT
                    end else begin
                        pc <= pc + data_w'(2);
                    end
                end
                st_drain: begin
                    // Wait for older instructions and the HLT to leave
                    if (halt_retired) begin
                        state <= st_halted;
                    end
                end
                default: state <= st_halted;   // Halted until reset
            endcase
        end
    end

    // Fetch is dropped in the same cycle the HLT is decoded
    assign fetch_valid = (state == st_run) && !halt_seen;

    // Rise with the HLT in MEM/WB, then hold
    assign hlt = (state == st_halted) || ((state == st_drain) && halt_retired);

    // ------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------
    a_pc_frozen: assert property (@(posedge clk) disable iff (rst)
        (state != st_run) |=> $stable(pc));

    a_hlt_sticky: assert property (@(posedge clk) disable iff (rst)
        $fell(hlt) |-> $past(rst));

endmodule

//--- src/forward_unit.sv
// Operand forwarding for the execute stage
// EX/MEM beats MEM/WB, which beats the register file value

`timescale 1ns/1ps

module forward_unit
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;
(
    input  logic [reg_addr_w-1:0] id_rs,
    input  logic [reg_addr_w-1:0] id_rt,
    input  logic [data_w-1:0]     id_a,
    input  logic [data_w-1:0]     id_b,
    input  ex_mem_t               ex_mem,
    input  mem_wb_t               mem_wb,
    output logic [data_w-1:0]     fwd_a,
    output logic [data_w-1:0]     fwd_b
);

    logic [1:0] sel_a;
    logic [1:0] sel_b;

    // Pick the youngest in-flight writer of spec
    function automatic logic [1:0] fwd_sel(input logic [reg_addr_w-1:0] spec);
        logic [1:0] s;
        if (spec == '0) begin
            s = fwd_sel_none;                          // r0 never forwards
        end else if (ex_mem.valid && ex_mem.reg_write && (ex_mem.dst == spec)) begin
            s = fwd_sel_exmem;
        end else if (mem_wb.valid && mem_wb.reg_write && (mem_wb.dst == spec)) begin
            s = fwd_sel_memwb;
        end else begin
            s = fwd_sel_none;
        end
        return s;
    endfunction

    function automatic logic [data_w-1:0] fwd_mux(input logic [1:0] s,
                                                 input logic [data_w-1:0] rf_val);
        logic [data_w-1:0] v;
        case (s)
            fwd_sel_exmem: v = ex_mem.result;
            fwd_sel_memwb: v = mem_wb.result;
            default:       v = rf_val;
        endcase
        return v;
    endfunction

    always_comb begin
        sel_a = fwd_sel(id_rs);
        sel_b = fwd_sel(id_rt);
        fwd_a = fwd_mux(sel_a, id_a);
        fwd_b = fwd_mux(sel_b, id_b);
    end

endmodule

//--- src/retire_stage.sv
// Retire stages
// EX/MEM and MEM/WB registers, memory slot passes results through
// Forms the register write port and flags the retiring HLT

`timescale 1ns/1ps

module retire_stage
    import cpu_pipe_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  ex_mem_t ex,
    output ex_mem_t ex_mem,
    output mem_wb_t mem_wb,
    output wb_t     wb,
    output logic    halt_retired
);

    // ------------------------------------------------------------------
    // EX/MEM and MEM/WB
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_mem.valid     <= 1'b0;
            ex_mem.reg_write <= 1'b0;
            ex_mem.halt      <= 1'b0;
            mem_wb.valid     <= 1'b0;
            mem_wb.reg_write <= 1'b0;
            mem_wb.halt      <= 1'b0;
        end else begin
            ex_mem <= ex;
            mem_wb <= ex_mem;   // No memory access in this slot
        end
    end

    // Write port, one pulse per retiring writer
    assign wb.en   = mem_wb.valid && mem_wb.reg_write;
    assign wb.dst  = mem_wb.dst;
    assign wb.data = mem_wb.result;

    assign halt_retired = mem_wb.valid && mem_wb.halt;

    // Decode never marks an r0 destination as a write
    a_wb_dst: assert property (@(posedge clk) disable iff (rst)
        wb.en |-> (wb.dst != '0));

endmodule

//--- tests/cpu_tb.sv
// Testbench for the 16-bit pipeline
// Generates random programs, serves them at pc, runs a sequential
// reference model and compares every retiring register write

`timescale 1ns/1ps

module cpu_tb
    import cpu_isa_pkg::*;
    import cpu_pipe_pkg::*;
;

    localparam int clk_half     = 10;    // 20 ns period
    localparam int reset_cycles = 8;
    localparam int hold_cycles  = 20;    // Halt must hold this long
    localparam int prog_max     = 64;
    localparam int n_chain      = 24;
    localparam int n_pairs      = 10;
    localparam int n_const      = 6;
    localparam int n_rand       = 30;
    // Longest program of each test
    localparam int len_total = (8 + n_chain + 1) + (4 + 4 * n_pairs + 1)
                             + (2 * n_const + 5) + (n_rand + 9);
    localparam int watchdog_cycles = 20 * len_total + 100;

    localparam logic [data_w-1:0] nop_word = {op_nop, 12'h000};
    localparam logic [data_w-1:0] hlt_word = {op_hlt, 12'h000};

    typedef struct packed {
        logic [reg_addr_w-1:0] dst;
        logic [data_w-1:0]     data;
    } exp_wr_t;

    logic              clk = 1'b0;
    logic              rst;
    logic [data_w-1:0] instr;
    logic [data_w-1:0] pc;
    logic              hlt;
    wb_t               wb;

    logic [data_w-1:0] prog [prog_max];   // Program image, word per pc/2
    int                prog_len;
    int                prog_rev = 0;      // Bumped on every new program
    exp_wr_t           exp_q [$];         // Expected writes, oldest first

    cpu dut_i (
        .clk   (clk),
        .rst   (rst),
        .instr (instr),
        .pc    (pc),
        .hlt   (hlt),
        .wb    (wb)
    );

    always #(clk_half) clk = ~clk;

    // ------------------------------------------------------------------
    // Error reporting
    // ------------------------------------------------------------------
    task automatic report_failure(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic report_mismatch(input string sig, input logic [data_w-1:0] got,
                                   input logic [data_w-1:0] exp);
        report_failure($sformatf("Fail at %0d ns: %s is %h, expected %h",
                                 $time, sig, got, exp));
    endtask

    // ------------------------------------------------------------------
    // Program building
    // ------------------------------------------------------------------
    function automatic logic [data_w-1:0] r_word(input logic [3:0] op, rd, rs, rt);
        return {op, rd, rs, rt};
    endfunction

    function automatic logic [data_w-1:0] i_word(input logic [3:0] op, rd,
                                                 input logic [imm_w-1:0] imm);
        return {op, rd, imm};
    endfunction

    function automatic logic [3:0] rand_reg(input bit allow_zero);
        return allow_zero ? 4'($urandom_range(15)) : 4'($urandom_range(15, 1));
    endfunction

    function automatic logic [3:0] rand_alu_op();
        logic [3:0] op;
        case ($urandom_range(4))
            0:       op = op_add;
            1:       op = op_sub;
            2:       op = op_and;
            3:       op = op_xor;
            default: op = op_sll;
        endcase
        return op;
    endfunction

    task automatic clear_program();
        prog_len = 0;
        for (int i = 0; i < prog_max; i++) begin
            prog[i] = nop_word;
        end
    endtask

    task automatic push_word(input logic [data_w-1:0] w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    // LDI/LHB seeds, then a chain where rs is always the last rd
    task automatic gen_chain();
        logic [3:0] prev;
        logic [3:0] rd;
        logic [3:0] rt;
        clear_program();
        for (int r = 1; r <= 4; r++) begin
            push_word(i_word(op_ldi, 4'(r), 8'($urandom)));
            push_word(i_word(op_lhb, 4'(r), 8'($urandom)));
        end
        prev = 4'd4;
        repeat (n_chain) begin
            rd = rand_reg(0);
            rt = ($urandom_range(1) == 1) ? prev : rand_reg(1);   // Sometimes both
            push_word(r_word(rand_alu_op(), rd, prev, rt));
            prev = rd;
        end
        push_word(hlt_word);
        prog_rev++;
    endtask

    // Producer, one or two NOPs, consumer; every fourth producer hits r0
    task automatic gen_distance();
        logic [3:0] rd;
        clear_program();
        for (int r = 1; r <= 4; r++) begin
            push_word(i_word(op_ldi, 4'(r), 8'($urandom)));
        end
        for (int i = 0; i < n_pairs; i++) begin
            rd = ((i % 4) == 3) ? 4'd0 : rand_reg(0);
            push_word(r_word(rand_alu_op(), rd, rand_reg(0), rand_reg(0)));
            repeat ($urandom_range(2, 1)) push_word(nop_word);
            push_word(r_word(rand_alu_op(), rand_reg(0), rd,
                             ($urandom_range(1) == 1) ? rd : rand_reg(1)));
        end
        push_word(hlt_word);
        prog_rev++;
    endtask

    // 16-bit constants from LDI then LHB on the same register
    task automatic gen_immediates();
        logic [3:0] rd;
        clear_program();
        repeat (n_const) begin
            rd = rand_reg(0);
            push_word(i_word(op_ldi, rd, 8'($urandom)));
            push_word(i_word(op_lhb, rd, 8'($urandom)));
        end
        repeat (4) push_word(r_word(rand_alu_op(), rand_reg(0), rand_reg(0), rand_reg(0)));
        push_word(hlt_word);
        prog_rev++;
    endtask

    // Any opcode but HLT, then HLT and unrestricted garbage
    task automatic gen_halt();
        logic [data_w-1:0] w;
        clear_program();
        repeat (n_rand) begin
            w        = 16'($urandom);
            w[15:12] = 4'($urandom_range(14));
            push_word(w);
        end
        push_word(hlt_word);
        repeat (8) push_word(16'($urandom));
        prog_rev++;
    endtask

    // ------------------------------------------------------------------
    // Reference model, runs the program in order up to HLT
    // ------------------------------------------------------------------
    function automatic void build_expected();
        logic [data_w-1:0] rf [reg_count];
        logic [data_w-1:0] w;
        logic [data_w-1:0] a;
        logic [data_w-1:0] b;
        logic [data_w-1:0] res;
        logic [3:0]        op;
        logic [3:0]        rd;
        logic              writes;
        exp_q.delete();
        for (int i = 0; i < reg_count; i++) begin
            rf[i] = '0;
        end
        for (int k = 0; k < prog_len; k++) begin
            w  = prog[k];
            op = w[15:12];
            rd = w[11:8];
            if (op == op_hlt) break;
            a      = rf[w[7:4]];
            b      = rf[w[3:0]];
            writes = 1'b1;
            case (op)
                op_add:  res = a + b;
                op_sub:  res = a - b;
                op_and:  res = a & b;
                op_xor:  res = a ^ b;
                op_sll:  res = a << b[3:0];
                op_ldi:  res = {8'h00, w[7:0]};
                op_lhb:  res = {w[7:0], rf[rd][7:0]};   // Keeps old low byte
                default: writes = 1'b0;                 // NOP and unused codes
            endcase
            if (writes && (rd != 4'd0)) begin
                rf[rd] = res;
                exp_q.push_back('{dst: rd, data: res});
            end
        end
    endfunction

    // ------------------------------------------------------------------
    // Instruction source, returns the word at pc in the same cycle
    // ------------------------------------------------------------------
    function automatic logic [data_w-1:0] word_at(input logic [data_w-1:0] addr);
        logic [data_w-1:0] w;
        if ($isunknown(addr) || (int'(addr[15:1]) >= prog_len)) begin
            w = nop_word;
        end else begin
            w = prog[addr[15:1]];
        end
        return w;
    endfunction

    always @(pc or prog_rev) instr <= word_at(pc);   // pc moves only at posedge

    // ------------------------------------------------------------------
    // Compare process, wb sampled mid-cycle
    // ------------------------------------------------------------------
    always @(negedge clk) begin
        exp_wr_t e;
        if (rst === 1'b0) begin
            assert (!(hlt && wb.en)) else report_failure("Register write seen after hlt rose");
            if (wb.en === 1'b1) begin
                assert (exp_q.size() > 0) else
                    report_failure($sformatf("Unexpected write to r%0d at %0d ns",
                                             wb.dst, $time));
                e = exp_q.pop_front();
                assert (wb.dst === e.dst) else report_mismatch("wb.dst", 16'(wb.dst), 16'(e.dst));
                assert (wb.data === e.data) else report_mismatch("wb.data", wb.data, e.data);
            end
        end
    end

    // ------------------------------------------------------------------
    // Sequencing
    // ------------------------------------------------------------------
    task automatic check_idle();
        assert (hlt === 1'b0) else report_mismatch("hlt", 16'(hlt), 16'h0000);
        assert (wb.en === 1'b0) else report_mismatch("wb.en", 16'(wb.en), 16'h0000);
        assert (pc === 16'h0000) else report_mismatch("pc", pc, 16'h0000);
    endtask

    // Entered at a rising edge, the DUT takes the reset at the next one
    task automatic apply_reset();
        rst <= 1'b1;
        @(posedge clk);
        repeat (reset_cycles - 1) begin
            @(negedge clk);
            check_idle();
            @(posedge clk);
        end
        rst <= 1'b0;
        @(negedge clk);
        check_idle();   // First cycle out of reset
    endtask

    task automatic run_program();
        build_expected();
        @(posedge clk);
        apply_reset();
        while (hlt !== 1'b1) @(negedge clk);
        assert (exp_q.size() == 0) else
            report_failure($sformatf("%0d expected writes missing when hlt rose",
                                     exp_q.size()));
    endtask

    task automatic check_halt_hold();
        logic [data_w-1:0] pc_hold;
        pc_hold = pc;
        repeat (hold_cycles) begin
            @(negedge clk);
            assert (hlt === 1'b1) else report_failure("hlt fell while the core was halted");
            assert (pc === pc_hold) else report_mismatch("pc", pc, pc_hold);
        end
    endtask

    initial begin
        void'($urandom(32'h1c4f));
        rst   <= 1'b1;
        instr <= nop_word;
        gen_chain();
        run_program();
        gen_distance();
        run_program();
        gen_immediates();
        run_program();
        gen_halt();
        run_program();
        check_halt_hold();
        $display("*** TEST PASSED ***");
        $finish;
    end

    // Watchdog sized from the longest programs
    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        report_failure($sformatf("Timeout, run did not finish in %0d cycles",
                                 watchdog_cycles));
    end

endmodule
